//--- Bender.yml
package:
  name: rvfi_tracer

sources:
  - include_dirs:
      - src
    files:
      - src/rvfi_pkg.sv
      - src/rvfi_issue_latch.sv
      - src/rvfi_sb_mem.sv
      - src/rvfi_commit_pack.sv
      - src/rvfi_tracer.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_rvfi_tracer.sv

//--- dv/rvfi_stimulus.txt
# P test fv finsn fc iack flush dv dack fun iptr rnd rs1 rs2 lv lst laddr be id lwd cp0 cp1 cv ca exv cause priv dbg chk
# E port valid trap insn rs1 rs2 addr rmask wmask wdata mode (rs ignored for random entries)
P 1 1 dead4501 1 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 1 1 00c58533 0 1 0 1 1 0 1 0 11111111 22222222 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 1 0 00000000 0 1 0 1 1 0 2 0 33333333 44444444 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 1 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 2 3 3 0 00 3 0 1
E 0 1 0 00004501 11111111 22222222 00000000 0 0 00000000 3
E 1 1 0 00c58533 33333333 44444444 00000000 0 0 00000000 3
P 2 1 00208093 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 2 1 002081b3 0 1 0 1 1 0 3 1 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 2 0 00000000 0 1 0 1 1 0 4 1 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 2 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 3 4 3 3 0 00 3 0 1
E 0 1 0 00208093 00000000 00000000 00000000 0 0 00000000 3
E 1 1 0 002081b3 00000000 00000000 00000000 0 0 00000000 3
P 3 1 0040a103 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 3 1 0020a223 0 1 0 1 1 0 5 0 00001000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 3 0 00000000 0 1 0 1 1 0 6 0 00002000 cafef00d 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 3 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 1 1 00002004 f 6 cafef00d 0 0 0 0 0 00 3 0 0
P 3 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 1 0 00001000 3 5 00000000 0 0 0 0 0 00 3 0 0
P 3 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 5 6 3 3 0 00 3 0 1
E 0 1 0 0040a103 00001000 00000000 00001000 3 0 00000000 3
E 1 1 0 0020a223 00002000 cafef00d 00002004 0 f cafef00d 3
P 4 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 2 1 0 1 0b 3 0 1
E 0 1 1 00004501 11111111 22222222 00000000 0 0 00000000 3
E 1 0 0 00c58533 33333333 44444444 00000000 0 0 00000000 3
P 4 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 2 1 0 1 02 3 0 1
E 0 0 1 00004501 11111111 22222222 00000000 0 0 00000000 3
E 1 0 0 00c58533 33333333 44444444 00000000 0 0 00000000 3
P 4 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 2 3 3 0 00 3 0 1
E 0 1 0 00004501 11111111 22222222 00000000 0 0 00000000 3
E 1 1 0 00c58533 33333333 44444444 00000000 0 0 00000000 3
P 4 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 2 3 0 1 08 0 0 1
E 0 1 1 00004501 11111111 22222222 00000000 0 0 00000000 0
E 1 1 1 00c58533 33333333 44444444 00000000 0 0 00000000 0
P 5 1 00100073 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 0 00000000 0 1 0 1 1 1 1 0 99999999 99999999 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 1 00500593 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 0 00000000 0 0 1 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 1 00600613 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 0 00000000 0 1 0 1 1 0 7 0 77777777 88888888 0 0 00000000 0 0 00000000 0 0 0 0 0 00 3 0 0
P 5 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 1 7 3 3 0 00 3 0 1
E 0 1 0 00004501 11111111 22222222 00000000 0 0 00000000 3
E 1 1 0 00600613 77777777 88888888 00000000 0 0 00000000 3
P 6 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 2 5 3 3 0 00 1 1 1
E 0 1 0 00c58533 33333333 44444444 00000000 0 0 00000000 2
E 1 1 0 0040a103 00001000 00000000 00001000 3 0 00000000 2
P 6 0 00000000 0 0 0 0 0 0 0 0 00000000 00000000 0 0 00000000 0 0 00000000 2 5 3 3 0 00 1 0 1
E 0 1 0 00c58533 33333333 44444444 00000000 0 0 00000000 1
E 1 1 0 0040a103 00001000 00000000 00001000 3 0 00000000 1

//--- dv/tb_clk_gen.sv
// Testbench clock and reset

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam real HALF_PERIOD = 5.0;   // 10 ns clock
  localparam int  RST_CYCLES  = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- dv/tb_rvfi_tracer.sv
// RVFI tracer testbench

`timescale 1ns/100ps

`include "rvfi_defs.svh"

module tb_rvfi_tracer;

  localparam int NR_TESTS    = 6;
  localparam int RST_TIMEOUT = 20;     // Cycles allowed for reset release
  localparam int MAX_LINES   = 1000;

  // --------------------------------------------------
  // DUT signals named like the ports
  // --------------------------------------------------

  logic clk_i, rst_ni;
  logic flush_i, fetch_valid_i, fetch_compressed_i, issue_ack_i;
  rvfi_pkg::insn_t fetch_insn_i;
  logic decoded_valid_i, decoded_ack_i, flush_unissued_i;
  rvfi_pkg::trans_id_t issue_ptr_i;
  rvfi_pkg::xlen_t rs1_fwd_i, rs2_fwd_i;
  logic lsu_valid_i, lsu_is_store_i;
  rvfi_pkg::xlen_t lsu_addr_i, lsu_wdata_i;
  rvfi_pkg::bytemask_t lsu_be_i;
  rvfi_pkg::trans_id_t lsu_trans_id_i;
  rvfi_pkg::trans_id_t [`RVFI_NR_COMMIT-1:0] commit_ptr_i;
  logic [`RVFI_NR_COMMIT-1:0] commit_valid_i, commit_ack_i;
  rvfi_pkg::xlen_t [`RVFI_NR_COMMIT-1:0] commit_pc_i, commit_result_i, commit_wdata_i;
  logic [`RVFI_NR_COMMIT-1:0][4:0] commit_rs1_i, commit_rs2_i, commit_rd_i;
  logic ex_valid_i, debug_mode_i;
  rvfi_pkg::cause_t ex_cause_i;
  rvfi_pkg::priv_t priv_i;

  logic [`RVFI_NR_COMMIT-1:0] rvfi_valid_o, rvfi_trap_o;
  rvfi_pkg::cause_t [`RVFI_NR_COMMIT-1:0] rvfi_cause_o;
  rvfi_pkg::priv_t [`RVFI_NR_COMMIT-1:0] rvfi_mode_o;
  rvfi_pkg::insn_t [`RVFI_NR_COMMIT-1:0] rvfi_insn_o;
  rvfi_pkg::xlen_t [`RVFI_NR_COMMIT-1:0] rvfi_pc_o, rvfi_rd_wdata_o;
  logic [`RVFI_NR_COMMIT-1:0][4:0] rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
  rvfi_pkg::xlen_t [`RVFI_NR_COMMIT-1:0] rvfi_rs1_rdata_o, rvfi_rs2_rdata_o;
  rvfi_pkg::xlen_t [`RVFI_NR_COMMIT-1:0] rvfi_mem_addr_o, rvfi_mem_wdata_o, rvfi_mem_rdata_o;
  rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0] rvfi_mem_rmask_o, rvfi_mem_wmask_o;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  rvfi_tracer i_dut (.*);

  // --------------------------------------------------
  // Stimulus line, expected values and reference model
  // --------------------------------------------------

  int fd;
  logic [31:0] f [28];                 // Probe columns of the current line
  logic [31:0] e [2][10];              // Expected record per port
  logic [31:0] drv_rs1, drv_rs2;
  logic [31:0] c_pc [2], c_res [2], c_wd [2];
  logic [4:0]  c_rs1 [2], c_rs2 [2], c_rd [2];
  bit          rnd_used [`RVFI_NR_SB];  // Entry holds random operands
  logic [31:0] rnd_rs1 [`RVFI_NR_SB], rnd_rs2 [`RVFI_NR_SB];
  int cur_test, test_errors, n_checks, tests_seen, tests_pass, tests_fail;
  bit aborted;

  task automatic read_line(output string s, output bit ok);
    s  = "";
    ok = 1'b0;
    while (!ok && !$feof(fd)) begin
      if ($fgets(s, fd) != 0 && s.len() > 1 && s[0] != "#") ok = 1'b1;
    end
  endtask

  task automatic read_expected();
    string s;
    bit ok;
    int n;
    logic [31:0] v [11];
    for (int k = 0; k < 2; k++) begin
      read_line(s, ok);
      n = ok ? $sscanf(s, "E %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                       v[4], v[5], v[6], v[7], v[8], v[9], v[10]) : 0;
      if (n != 11 || v[0] > 1) begin
        $display("Stimulus file lacks the expected values of test %0d", f[0]);
        aborted = 1'b1;
      end else begin
        for (int j = 0; j < 10; j++) e[v[0]][j] = v[j+1];
      end
    end
  endtask

  task automatic apply_probe();
    drv_rs1 = f[10][0] ? $urandom : f[11];  // Random operands when marked
    drv_rs2 = f[10][0] ? $urandom : f[12];
    fetch_valid_i      <= f[1][0];
    fetch_insn_i       <= f[2];
    fetch_compressed_i <= f[3][0];
    issue_ack_i        <= f[4][0];
    flush_i            <= f[5][0];
    decoded_valid_i    <= f[6][0];
    decoded_ack_i      <= f[7][0];
    flush_unissued_i   <= f[8][0];
    issue_ptr_i        <= f[9][2:0];
    rs1_fwd_i          <= drv_rs1;
    rs2_fwd_i          <= drv_rs2;
    lsu_valid_i        <= f[13][0];
    lsu_is_store_i     <= f[14][0];
    lsu_addr_i         <= f[15];
    lsu_be_i           <= f[16][3:0];
    lsu_trans_id_i     <= f[17][2:0];
    lsu_wdata_i        <= f[18];
    commit_ptr_i[0]    <= f[19][2:0];
    commit_ptr_i[1]    <= f[20][2:0];
    commit_valid_i     <= f[21][1:0];
    commit_ack_i       <= f[22][1:0];
    ex_valid_i         <= f[23][0];
    ex_cause_i         <= f[24];
    priv_i             <= f[25][1:0];
    debug_mode_i       <= f[26][0];
    // Pass-through fields get fresh random values every cycle
    for (int p = 0; p < 2; p++) begin
      c_pc[p]  = $urandom;
      c_res[p] = $urandom;
      c_wd[p]  = $urandom;
      c_rs1[p] = 5'($urandom);
      c_rs2[p] = 5'($urandom);
      c_rd[p]  = 5'($urandom);
      commit_pc_i[p]     <= c_pc[p];
      commit_result_i[p] <= c_res[p];
      commit_wdata_i[p]  <= c_wd[p];
      commit_rs1_i[p]    <= c_rs1[p];
      commit_rs2_i[p]    <= c_rs2[p];
      commit_rd_i[p]     <= c_rd[p];
    end
  endtask

  // Accepted decodes without a flush of unissued work overwrite the entry
  task automatic update_model();
    if (f[6][0] && f[7][0] && !f[8][0]) begin
      rnd_used[f[9][2:0]] = f[10][0];
      rnd_rs1[f[9][2:0]]  = drv_rs1;
      rnd_rs2[f[9][2:0]]  = drv_rs2;
    end
  endtask

  task automatic compare(input string what, input int p, input logic [31:0] got,
                         input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("[ERROR] %0t: test %0d port %0d %s is %08h, expected %08h",
               $time, cur_test, p, what, got, exp);
    end
  endtask

  task automatic check_port(input int p);
    int ptr;
    logic [31:0] x_rs1, x_rs2;
    ptr   = (p == 0) ? f[19][2:0] : f[20][2:0];
    x_rs1 = rnd_used[ptr] ? rnd_rs1[ptr] : e[p][3];
    x_rs2 = rnd_used[ptr] ? rnd_rs2[ptr] : e[p][4];
    compare("valid", p, rvfi_valid_o[p], e[p][0]);
    compare("trap", p, rvfi_trap_o[p], e[p][1]);
    compare("cause", p, rvfi_cause_o[p], f[24]);
    compare("insn", p, rvfi_insn_o[p], e[p][2]);
    compare("rs1_rdata", p, rvfi_rs1_rdata_o[p], x_rs1);
    compare("rs2_rdata", p, rvfi_rs2_rdata_o[p], x_rs2);
    compare("mem_addr", p, rvfi_mem_addr_o[p], e[p][5]);
    compare("mem_rmask", p, rvfi_mem_rmask_o[p], e[p][6]);
    compare("mem_wmask", p, rvfi_mem_wmask_o[p], e[p][7]);
    compare("mem_wdata", p, rvfi_mem_wdata_o[p], e[p][8]);
    compare("mode", p, rvfi_mode_o[p], e[p][9]);
    compare("pc", p, rvfi_pc_o[p], c_pc[p]);
    compare("rs1_addr", p, rvfi_rs1_addr_o[p], c_rs1[p]);
    compare("rs2_addr", p, rvfi_rs2_addr_o[p], c_rs2[p]);
    compare("rd_addr", p, rvfi_rd_addr_o[p], c_rd[p]);
    compare("rd_wdata", p, rvfi_rd_wdata_o[p], c_wd[p]);
    compare("mem_rdata", p, rvfi_mem_rdata_o[p], c_res[p]);
  endtask

  task automatic finish_test();
    if (cur_test != 0) begin
      tests_seen++;
      if (test_errors == 0) begin
        tests_pass++;
        $display("Test %0d passed", cur_test);
      end else begin
        tests_fail++;
        $display("Test %0d failed with %0d errors", cur_test, test_errors);
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    string s;
    bit ok;
    int n, waited, lines;
    {flush_i, fetch_valid_i, fetch_compressed_i, issue_ack_i} = '0;
    {decoded_valid_i, decoded_ack_i, flush_unissued_i, lsu_valid_i, lsu_is_store_i} = '0;
    {fetch_insn_i, issue_ptr_i, rs1_fwd_i, rs2_fwd_i} = '0;
    {lsu_addr_i, lsu_be_i, lsu_trans_id_i, lsu_wdata_i, commit_ptr_i} = '0;
    {commit_valid_i, commit_ack_i, commit_pc_i, commit_result_i, commit_wdata_i} = '0;
    {commit_rs1_i, commit_rs2_i, commit_rd_i, ex_valid_i, ex_cause_i} = '0;
    priv_i       = 2'd3;
    debug_mode_i = 1'b0;
    void'($urandom(91745));
    fd = $fopen("dv/rvfi_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/rvfi_stimulus.txt");
      aborted = 1'b1;
    end
    // Reset may still be unknown at time zero
    while (rst_ni !== 1'b1 && waited < RST_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Reset was not released within %0d cycles", RST_TIMEOUT);
      aborted = 1'b1;
    end
    while (!aborted && lines < MAX_LINES) begin
      read_line(s, ok);
      if (!ok) break;
      n = $sscanf(s,
        "P %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                  f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                  f[22], f[23], f[24], f[25], f[26], f[27]);
      if (n != 28) begin
        $display("Stimulus file has a malformed probe line: %s", s);
        aborted = 1'b1;
      end else begin
        if (f[0] != cur_test) begin
          finish_test();
          cur_test    = f[0];
          test_errors = 0;
        end
        if (f[27][0]) read_expected();
        if (!aborted) begin
          @(posedge clk_i);
          apply_probe();
          #1;                            // Let the combinational record settle
          if (f[27][0]) begin
            check_port(0);
            check_port(1);
          end
          update_model();
        end
      end
      lines++;
    end
    finish_test();
    if (fd != 0) $fclose(fd);
    if (!aborted && tests_seen < NR_TESTS) begin
      $display("Stimulus file ended after %0d of %0d tests", tests_seen, NR_TESTS);
      aborted = 1'b1;
    end
    $display("Tests passed %0d, failed %0d, checks %0d", tests_pass, tests_fail, n_checks);
    if (!aborted && tests_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/rvfi_pkg.sv
src/rvfi_issue_latch.sv
src/rvfi_sb_mem.sv
src/rvfi_commit_pack.sv
src/rvfi_tracer.sv
dv/tb_clk_gen.sv
dv/tb_rvfi_tracer.sv

//--- src/rvfi_commit_pack.sv
// Trace record assembly at commit

`timescale 1ns/100ps

`include "rvfi_defs.svh"

module rvfi_commit_pack (
  // Commit stage, one entry per port
  input  logic                [`RVFI_NR_COMMIT-1:0]       commit_valid_i,
  input  logic                [`RVFI_NR_COMMIT-1:0]       commit_ack_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_pc_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rs1_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rs2_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rd_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_result_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_wdata_i,
  // Shared core state
  input  logic                                            ex_valid_i,
  input  rvfi_pkg::cause_t                                ex_cause_i,
  input  rvfi_pkg::priv_t                                 priv_i,
  input  logic                                            debug_mode_i,
  // Scoreboard read data
  input  rvfi_pkg::insn_t     [`RVFI_NR_COMMIT-1:0]       sb_insn_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       sb_rs1_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       sb_rs2_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       sb_addr_i,
  input  rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       sb_rmask_i,
  input  rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       sb_wmask_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       sb_wdata_i,
  // Trace records
  output logic                [`RVFI_NR_COMMIT-1:0]       rvfi_valid_o,
  output logic                [`RVFI_NR_COMMIT-1:0]       rvfi_trap_o,
  output rvfi_pkg::cause_t    [`RVFI_NR_COMMIT-1:0]       rvfi_cause_o,
  output rvfi_pkg::priv_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mode_o,
  output rvfi_pkg::insn_t     [`RVFI_NR_COMMIT-1:0]       rvfi_insn_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_pc_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rs1_addr_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rs2_addr_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rd_addr_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rd_wdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rs1_rdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rs2_rdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_addr_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rvfi_mem_rmask_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rvfi_mem_wmask_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_wdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_rdata_o
);

  logic            is_ecall;
  rvfi_pkg::priv_t mode;

  // An ecall traps but is still architecturally executed
  assign is_ecall = (ex_cause_i == rvfi_pkg::CAUSE_ECALL_U) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_S) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_M);

  assign mode = debug_mode_i ? 2'b10 : priv_i;  // Debug reported as mode 2

  // -----------------------------------------------
  // Per port record
  // -----------------------------------------------

  for (genvar p = 0; p < `RVFI_NR_COMMIT; p++) begin : g_port
    assign rvfi_trap_o[p]  = commit_valid_i[p] && ex_valid_i;
    assign rvfi_valid_o[p] = (commit_ack_i[p] && !ex_valid_i) ||
                             (rvfi_trap_o[p] && is_ecall);
    assign rvfi_cause_o[p] = ex_cause_i;
    assign rvfi_mode_o[p]  = mode;

    assign rvfi_insn_o[p]     = sb_insn_i[p];
    assign rvfi_pc_o[p]       = commit_pc_i[p];
    assign rvfi_rs1_addr_o[p] = commit_rs1_i[p];
    assign rvfi_rs2_addr_o[p] = commit_rs2_i[p];
    assign rvfi_rd_addr_o[p]  = commit_rd_i[p];
    assign rvfi_rd_wdata_o[p] = commit_wdata_i[p];    // Value written back

    // Operands as seen at issue time
    assign rvfi_rs1_rdata_o[p] = sb_rs1_i[p];
    assign rvfi_rs2_rdata_o[p] = sb_rs2_i[p];

    assign rvfi_mem_addr_o[p]  = sb_addr_i[p];
    assign rvfi_mem_rmask_o[p] = sb_rmask_i[p];
    assign rvfi_mem_wmask_o[p] = sb_wmask_i[p];
    assign rvfi_mem_wdata_o[p] = sb_wdata_i[p];
    assign rvfi_mem_rdata_o[p] = commit_result_i[p];  // Load result
  end

endmodule

//--- src/rvfi_defs.svh
// RVFI tracer sizes

`ifndef RVFI_DEFS_SVH
`define RVFI_DEFS_SVH

// -----------------------------------------------
// Datapath
// -----------------------------------------------

// Register and data width of the core
`define RVFI_XLEN 32

// -----------------------------------------------
// Retirement
// -----------------------------------------------

// Instructions that can retire in one cycle
`define RVFI_NR_COMMIT 2

// -----------------------------------------------
// Scoreboard
// -----------------------------------------------

`define RVFI_NR_SB 8       // Entries in the core scoreboard

// Index width into the scoreboard, log2 of RVFI_NR_SB
`define RVFI_TRANS_ID_W 3

`endif

//--- src/rvfi_issue_latch.sv
// Fetch to issue instruction latch

`timescale 1ns/100ps

module rvfi_issue_latch (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,             // Pipeline flush
  input  logic             fetch_valid_i,       // Fetch entry presented
  input  rvfi_pkg::insn_t  fetch_insn_i,
  input  logic             fetch_compressed_i,  // Only low half is meaningful
  input  logic             issue_ack_i,         // Decode took the held word
  output rvfi_pkg::insn_t  issue_insn_o,
  output logic             issue_valid_o
);

  rvfi_pkg::insn_t fetch_word;
  rvfi_pkg::insn_t insn_q;
  logic            valid_q;
  logic            load_en;

  // RVC words are traced as their 16 bit encoding
  assign fetch_word = fetch_compressed_i ? {16'h0000, fetch_insn_i[15:0]} : fetch_insn_i;

  // Room for a new word when empty or when the current one leaves
  assign load_en = fetch_valid_i && (!valid_q || issue_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      insn_q  <= '0;
    end else begin
      if (load_en) begin
        insn_q <= fetch_word;
      end
      if (flush_i) begin
        valid_q <= 1'b0;                      // Flush wins over everything
      end else if (load_en) begin
        valid_q <= 1'b1;
      end else if (issue_ack_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign issue_insn_o  = insn_q;
  assign issue_valid_o = valid_q;

  // -----------------------------------------------
  // Checks
  // -----------------------------------------------

  // Decode must not consume a word that fetch never delivered
  a_ack_needs_word: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> valid_q
  ) else $error("issue_ack_i while issue latch is empty");

endmodule

//--- src/rvfi_pkg.sv
// RVFI tracer types

`include "rvfi_defs.svh"

package rvfi_pkg;

  // -----------------------------------------------
  // Vector types
  // -----------------------------------------------

  // Register file value or memory data word
  typedef logic [`RVFI_XLEN-1:0] xlen_t;

  // Scoreboard slot of an instruction in flight
  typedef logic [`RVFI_TRANS_ID_W-1:0] trans_id_t;

  typedef logic [31:0] insn_t;                  // Raw instruction word

  // One enable bit per byte lane of a data word
  typedef logic [`RVFI_XLEN/8-1:0] bytemask_t;

  typedef logic [1:0] priv_t;                   // U=0, S=1, M=3

  // mcause encoding, full register width
  typedef xlen_t cause_t;

  // -----------------------------------------------
  // Exception causes
  // -----------------------------------------------

  // Environment calls still count as retired instructions
  localparam cause_t CAUSE_ECALL_U = cause_t'(8);
  localparam cause_t CAUSE_ECALL_S = cause_t'(9);
  localparam cause_t CAUSE_ECALL_M = cause_t'(11);

endpackage

//--- src/rvfi_sb_mem.sv
// Scoreboard shadow storage for trace data

`timescale 1ns/100ps

`include "rvfi_defs.svh"

module rvfi_sb_mem (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Decode side
  input  logic                                            decoded_valid_i,
  input  logic                                            decoded_ack_i,
  input  logic                                            flush_unissued_i,
  input  rvfi_pkg::trans_id_t                             issue_ptr_i,
  input  rvfi_pkg::insn_t                                 issue_insn_i,
  input  rvfi_pkg::xlen_t                                 rs1_fwd_i,
  input  rvfi_pkg::xlen_t                                 rs2_fwd_i,
  // Load/store unit request
  input  logic                                            lsu_valid_i,
  input  logic                                            lsu_is_store_i,
  input  rvfi_pkg::xlen_t                                 lsu_addr_i,
  input  rvfi_pkg::bytemask_t                             lsu_be_i,
  input  rvfi_pkg::trans_id_t                             lsu_trans_id_i,
  input  rvfi_pkg::xlen_t                                 lsu_wdata_i,
  // Read back at commit
  input  rvfi_pkg::trans_id_t [`RVFI_NR_COMMIT-1:0]       commit_ptr_i,
  output rvfi_pkg::insn_t     [`RVFI_NR_COMMIT-1:0]       rd_insn_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rd_rs1_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rd_rs2_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rd_addr_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rd_rmask_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rd_wmask_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rd_wdata_o
);

  // One slot per scoreboard entry
  rvfi_pkg::insn_t     insn_q  [`RVFI_NR_SB];
  rvfi_pkg::xlen_t     rs1_q   [`RVFI_NR_SB];
  rvfi_pkg::xlen_t     rs2_q   [`RVFI_NR_SB];
  rvfi_pkg::xlen_t     addr_q  [`RVFI_NR_SB];
  rvfi_pkg::bytemask_t rmask_q [`RVFI_NR_SB];
  rvfi_pkg::bytemask_t wmask_q [`RVFI_NR_SB];
  rvfi_pkg::xlen_t     wdata_q [`RVFI_NR_SB];

  logic decode_we;

  // Unissued instructions being flushed never reach the scoreboard
  assign decode_we = decoded_valid_i && decoded_ack_i && !flush_unissued_i;

  // -----------------------------------------------
  // Write side
  // -----------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RVFI_NR_SB; i++) begin
        insn_q[i]  <= '0;
        rs1_q[i]   <= '0;
        rs2_q[i]   <= '0;
        addr_q[i]  <= '0;
        rmask_q[i] <= '0;
        wmask_q[i] <= '0;
        wdata_q[i] <= '0;
      end
    end else begin
      if (decode_we) begin
        insn_q[issue_ptr_i]  <= issue_insn_i;
        rs1_q[issue_ptr_i]   <= rs1_fwd_i;
        rs2_q[issue_ptr_i]   <= rs2_fwd_i;
        addr_q[issue_ptr_i]  <= '0;            // Fresh entry has no access yet
        rmask_q[issue_ptr_i] <= '0;
        wmask_q[issue_ptr_i] <= '0;
        wdata_q[issue_ptr_i] <= '0;
      end
      // Later assignment wins if the LSU hits the entry just decoded
      if (lsu_valid_i) begin
        addr_q[lsu_trans_id_i] <= lsu_addr_i;
        if (lsu_is_store_i) begin
          wmask_q[lsu_trans_id_i] <= lsu_be_i;
          wdata_q[lsu_trans_id_i] <= lsu_wdata_i;
        end else begin
          rmask_q[lsu_trans_id_i] <= lsu_be_i;
        end
      end
    end
  end

  // -----------------------------------------------
  // Read side, one port per commit slot
  // -----------------------------------------------

  for (genvar p = 0; p < `RVFI_NR_COMMIT; p++) begin : g_rd
    assign rd_insn_o[p]  = insn_q[commit_ptr_i[p]];
    assign rd_rs1_o[p]   = rs1_q[commit_ptr_i[p]];
    assign rd_rs2_o[p]   = rs2_q[commit_ptr_i[p]];
    assign rd_addr_o[p]  = addr_q[commit_ptr_i[p]];
    assign rd_rmask_o[p] = rmask_q[commit_ptr_i[p]];
    assign rd_wmask_o[p] = wmask_q[commit_ptr_i[p]];
    assign rd_wdata_o[p] = wdata_q[commit_ptr_i[p]];
  end

  // An LSU request with no byte lanes would leave the entry unmarked
  a_lsu_be_set: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_i |-> (lsu_be_i != '0)
  ) else $error("LSU request without byte enables");

endmodule

//--- src/rvfi_tracer.sv
// RVFI instruction trace monitor

`timescale 1ns/100ps

`include "rvfi_defs.svh"

module rvfi_tracer (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Fetch and issue
  input  logic                                            flush_i,
  input  logic                                            fetch_valid_i,
  input  rvfi_pkg::insn_t                                 fetch_insn_i,
  input  logic                                            fetch_compressed_i,
  input  logic                                            issue_ack_i,
  // Decode and scoreboard
  input  logic                                            decoded_valid_i,
  input  logic                                            decoded_ack_i,
  input  logic                                            flush_unissued_i,
  input  rvfi_pkg::trans_id_t                             issue_ptr_i,
  input  rvfi_pkg::xlen_t                                 rs1_fwd_i,
  input  rvfi_pkg::xlen_t                                 rs2_fwd_i,
  // Load/store unit
  input  logic                                            lsu_valid_i,
  input  logic                                            lsu_is_store_i,
  input  rvfi_pkg::xlen_t                                 lsu_addr_i,
  input  rvfi_pkg::bytemask_t                             lsu_be_i,
  input  rvfi_pkg::trans_id_t                             lsu_trans_id_i,
  input  rvfi_pkg::xlen_t                                 lsu_wdata_i,
  // Commit
  input  rvfi_pkg::trans_id_t [`RVFI_NR_COMMIT-1:0]       commit_ptr_i,
  input  logic                [`RVFI_NR_COMMIT-1:0]       commit_valid_i,
  input  logic                [`RVFI_NR_COMMIT-1:0]       commit_ack_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_pc_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rs1_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rs2_i,
  input  logic                [`RVFI_NR_COMMIT-1:0][4:0]  commit_rd_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_result_i,
  input  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       commit_wdata_i,
  input  logic                                            ex_valid_i,
  input  rvfi_pkg::cause_t                                ex_cause_i,
  input  rvfi_pkg::priv_t                                 priv_i,
  input  logic                                            debug_mode_i,
  // Trace records
  output logic                [`RVFI_NR_COMMIT-1:0]       rvfi_valid_o,
  output logic                [`RVFI_NR_COMMIT-1:0]       rvfi_trap_o,
  output rvfi_pkg::cause_t    [`RVFI_NR_COMMIT-1:0]       rvfi_cause_o,
  output rvfi_pkg::priv_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mode_o,
  output rvfi_pkg::insn_t     [`RVFI_NR_COMMIT-1:0]       rvfi_insn_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_pc_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rs1_addr_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rs2_addr_o,
  output logic                [`RVFI_NR_COMMIT-1:0][4:0]  rvfi_rd_addr_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rd_wdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rs1_rdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_rs2_rdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_addr_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rvfi_mem_rmask_o,
  output rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]       rvfi_mem_wmask_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_wdata_o,
  output rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]       rvfi_mem_rdata_o
);

  rvfi_pkg::insn_t                            issue_insn;  // Word waiting for decode
  rvfi_pkg::insn_t     [`RVFI_NR_COMMIT-1:0]  rd_insn;
  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]  rd_rs1;
  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]  rd_rs2;
  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]  rd_addr;
  rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]  rd_rmask;
  rvfi_pkg::bytemask_t [`RVFI_NR_COMMIT-1:0]  rd_wmask;
  rvfi_pkg::xlen_t     [`RVFI_NR_COMMIT-1:0]  rd_wdata;

  // Ports named like the top level connect by name
  rvfi_issue_latch i_issue_latch (
    .issue_insn_o  (issue_insn),
    .issue_valid_o (),             // Only checked inside the latch
    .*
  );

  rvfi_sb_mem i_sb_mem (
    .issue_insn_i (issue_insn),
    .rd_insn_o    (rd_insn),
    .rd_rs1_o     (rd_rs1),
    .rd_rs2_o     (rd_rs2),
    .rd_addr_o    (rd_addr),
    .rd_rmask_o   (rd_rmask),
    .rd_wmask_o   (rd_wmask),
    .rd_wdata_o   (rd_wdata),
    .*
  );

  rvfi_commit_pack i_commit_pack (
    .sb_insn_i  (rd_insn),
    .sb_rs1_i   (rd_rs1),
    .sb_rs2_i   (rd_rs2),
    .sb_addr_i  (rd_addr),
    .sb_rmask_i (rd_rmask),
    .sb_wmask_i (rd_wmask),
    .sb_wdata_i (rd_wdata),
    .*
  );

endmodule
